/* sprite_controller.f */
src/sprite_pkg.sv
src/bram.sv
src/sprite_attr_regs.sv
src/sprite_renderer.sv
src/scanline_buffer.sv
src/sprite_controller.sv
tb/tb_sprite_memory.sv
tb/tb_sprite_controller.sv

/* Makefile */
TOOL       = verilator
TOP        = tb_sprite_controller
FILELIST   = sprite_controller.f
LINT_FLAGS = --lint-only --timing -Wall
SIM_FLAGS  = --binary --timing -j 0
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/tb_sprite_controller.sv */
/*
 * Testbench for the scanline sprite controller
 *
 * Loads random sprite tables, runs display lines and compares every
 * colour index and the sheet read count with a line model
 */

module tb_sprite_controller;

	import sprite_pkg::*;

	localparam int DRIVE_DELAY = 5;
	localparam int RENDER_TIMEOUT = 4000;

	logic                      CLK = 1'b0;
	logic                      RSTb;
	logic [HOST_ADDR_BITS-1:0] ADDRESS;
	logic [WORD_BITS-1:0]      DATA_IN;
	logic                      WR;
	logic                      H_tick;
	logic [X_BITS-1:0]         display_x;
	logic [X_BITS-1:0]         display_y;
	pixel_t                    color_index;
	logic [MEM_ADDR_BITS-1:0]  memory_address;
	logic [WORD_BITS-1:0]      memory_data;
	logic                      rvalid;
	logic                      rready;
	logic                      render_busy;
	logic [1:0]                rdelay;
	logic                      rand_delay;
	int                        reads;
	int                        fetch_cycles = 0;
	int                        errors = 0;
	int                        checks = 0;
	logic [31:0]               lcg_state = 32'd86;

	// Testbench copy of the sprite table and the expected line
	sprite_attr_t              spr [SPRITE_COUNT];
	logic [7:0]                exp_line [SCREEN_W];
	int                        exp_reads;

	sprite_controller DUT (
		.CLK(CLK), .RSTb(RSTb), .ADDRESS(ADDRESS), .DATA_IN(DATA_IN), .WR(WR),
		.H_tick(H_tick), .display_x(display_x), .display_y(display_y),
		.color_index(color_index), .memory_address(memory_address),
		.memory_data(memory_data), .rvalid(rvalid), .rready(rready),
		.render_busy(render_busy)
	);

	tb_sprite_memory sheet_mem (
		.CLK(CLK), .RSTb(RSTb), .rvalid(rvalid), .memory_address(memory_address),
		.rdelay(rdelay), .rready(rready), .memory_data(memory_data), .reads(reads)
	);

	always #20 CLK = ~CLK;

	always @(posedge CLK) begin
		if (rvalid) begin
			fetch_cycles <= fetch_cycles + 1;
		end
	end

	function automatic int rand_range(int n);
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return int'(lcg_state[31:16]) % n;
	endfunction

	task automatic next_cycle();
		@(posedge CLK);
		#DRIVE_DELAY;
		rdelay = rand_delay ? 2'(rand_range(4)) : 2'd0;
	endtask

	task automatic check_value(logic [31:0] got, logic [31:0] exp, string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic finish_run();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	endtask

	task automatic write_word(logic [1:0] sel, int idx, logic [15:0] data);
		ADDRESS = {sel, 8'(idx)};
		DATA_IN = data;
		WR = 1'b1;
		next_cycle();
		WR = 1'b0;
	endtask

	task automatic write_sprite(int i);
		write_word(SEL_XRAM, i, spr[i].x);
		write_word(SEL_YRAM, i, spr[i].y);
		write_word(SEL_HRAM, i, 16'(spr[i].y_end));
		write_word(SEL_ARAM, i, spr[i].sheet_addr);
	endtask

	// Random sprite covering row y, or starting below it when off_line
	task automatic make_sprite(int i, int y, logic en, logic off_line);
		spr[i].x.x_pos = 10'(rand_range(SCREEN_W - 16));
		spr[i].x.enable = en;
		spr[i].x.pal_high = 4'(rand_range(16));
		spr[i].x.stride_wide = 1'(rand_range(2));
		spr[i].y.width = 6'(rand_range(16));
		spr[i].y.y_start = 10'(y - rand_range(20));
		spr[i].y_end = 10'(y + rand_range(20));
		if (off_line) begin
			spr[i].y.y_start = 10'(y + 1 + rand_range(20));
		end
		spr[i].sheet_addr = 16'(rand_range(65536));
		write_sprite(i);
	endtask

	task automatic disable_all();
		for (int i = 0; i < SPRITE_COUNT; i++) begin
			spr[i].x.enable = 1'b0;
			write_word(SEL_XRAM, i, spr[i].x);
		end
	endtask

	// Expected line and sheet reads for row y
	task automatic build_line(int y);
		int v;
		int nib;
		int stride;
		logic [15:0] w;
		logic [3:0] p;
		exp_reads = 0;
		for (int x = 0; x < SCREEN_W; x++) begin
			exp_line[x] = 8'd0;
		end
		// Ascending index, so later sprites win
		for (int i = 0; i < SPRITE_COUNT; i++) begin
			if (spr[i].x.enable && y >= int'(spr[i].y.y_start) && y <= int'(spr[i].y_end)) begin
				v = y - int'(spr[i].y.y_start);
				stride = spr[i].x.stride_wide ? STRIDE_WIDE : STRIDE_NARROW;
				exp_reads += (int'(spr[i].y.width) + 4) / 4;
				for (int u = 0; u <= int'(spr[i].y.width); u++) begin
					nib = (4 * int'(spr[i].sheet_addr) + v * stride + u) % (1 << NIBBLE_ADDR_BITS);
					w = sheet_mem.sheet[nib / 4];
					p = w[4 * (nib % 4) +: 4];
					if (p != 4'd0) begin
						exp_line[int'(spr[i].x.x_pos) + u] = {spr[i].x.pal_high, p};
					end
				end
			end
		end
	endtask

	task automatic wait_render();
		int n;
		n = 0;
		while (render_busy && n < RENDER_TIMEOUT) begin
			next_cycle();
			n++;
		end
		if (render_busy) begin
			errors++;
			$display("Render overrun: render_busy still high %0d cycles after the line", n);
			finish_run();
		end
	endtask

	// Start row y, show and check the row rendered before it
	task automatic run_line(int y, logic check);
		int reads_at;
		int fetch_at;
		display_y = 10'(y);
		H_tick = 1'b1;
		next_cycle();
		H_tick = 1'b0;
		check_value(32'(render_busy), 32'd1, "render_busy after H_tick");
		reads_at = reads;
		fetch_at = fetch_cycles;
		for (int x = 0; x < SCREEN_W; x++) begin
			display_x = 10'(x);
			next_cycle();
			if (check) begin
				check_value(32'(color_index), 32'(exp_line[x]),
					$sformatf("color_index at x=%0d", x));
			end
		end
		wait_render();
		build_line(y);
		check_value(reads - reads_at, exp_reads, $sformatf("sheet reads for row %0d", y));
		if (exp_reads == 0) begin
			check_value(fetch_cycles - fetch_at, 0, "rvalid cycles on a row without sprites");
		end
	endtask

	initial begin
		logic [15:0] w;
		logic [7:0] m;
		int idx;
		int y;
		RSTb = 1'b0;
		ADDRESS = '0;
		DATA_IN = '0;
		WR = 1'b0;
		H_tick = 1'b0;
		display_x = '0;
		display_y = '0;
		rdelay = 2'd0;
		rand_delay = 1'b0;
		// Sheet words with about a quarter of the pixels transparent
		for (int a = 0; a < 65536; a++) begin
			w = 16'(rand_range(65536));
			m = 8'(rand_range(256));
			for (int k = 0; k < 4; k++) begin
				if (m[2 * k +: 2] == 2'd0) begin
					w[4 * k +: 4] = 4'd0;
				end
			end
			sheet_mem.sheet[a] = w;
		end
		repeat (8) next_cycle();
		RSTb = 1'b1;
		for (int i = 0; i < SPRITE_COUNT; i++) begin
			make_sprite(i, 0, 1'b0, 1'b0);
		end

		// Two unchecked lines clear both line RAMs
		run_line(0, 1'b0);
		run_line(0, 1'b0);

		// Nothing enabled
		run_line(100, 1'b1);

		// Single narrow sprite
		make_sprite(37, 120, 1'b1, 1'b0);
		spr[37].x.stride_wide = 1'b0;
		write_sprite(37);
		run_line(120, 1'b1);

		// Overlap at close x positions
		disable_all();
		for (int k = 0; k < 3; k++) begin
			idx = (k == 2) ? 200 : 10 + k;
			make_sprite(idx, 200, 1'b1, 1'b0);
			spr[idx].x.x_pos = 10'(400 + 3 * k);
			spr[idx].y.width = 6'd15;
			write_sprite(idx);
		end
		run_line(200, 1'b1);

		// Same line again with back-pressure on the sheet reads
		rand_delay = 1'b1;
		run_line(200, 1'b1);

		// Wide stride, rows outside the range and a disabled sprite
		disable_all();
		make_sprite(5, 300, 1'b1, 1'b0);
		spr[5].x.stride_wide = 1'b1;
		write_sprite(5);
		make_sprite(6, 300, 1'b1, 1'b1);
		make_sprite(7, 300, 1'b1, 1'b0);
		spr[7].y_end = 10'd299;
		write_sprite(7);
		make_sprite(8, 300, 1'b0, 1'b0);
		run_line(300, 1'b1);

		// Random lines of up to six sprites
		repeat (6) begin
			disable_all();
			y = 30 + rand_range(450);
			for (int k = 0; k < 6; k++) begin
				make_sprite(rand_range(SPRITE_COUNT), y, 1'b1, rand_range(4) == 0);
			end
			run_line(y, 1'b1);
		end

		// Last content shown, then an empty line proves the clear
		disable_all();
		run_line(50, 1'b1);
		run_line(50, 1'b1);
		finish_run();
	end

endmodule

/* tb/tb_sprite_memory.sv */
/*
 * Sprite-sheet memory model
 *
 * Answers the renderer's read channel from a word array that the
 * testbench fills, holding rready back by a per-request delay
 */

module tb_sprite_memory (
	input  logic        CLK,
	input  logic        RSTb,
	input  logic        rvalid,
	input  logic [15:0] memory_address,
	input  logic [1:0]  rdelay,
	output logic        rready,
	output logic [15:0] memory_data,
	output int          reads
);

	logic [15:0] sheet [65536];

	int waited;
	int target;

	// Earliest answer comes one cycle after the request is raised
	assign rready = rvalid && (waited > target);
	assign memory_data = rready ? sheet[memory_address] : 16'hxxxx;

	always @(posedge CLK) begin
		if (!RSTb) begin
			waited <= 0;
			target <= 0;
			reads <= 0;
		end else if (rvalid && rready) begin
			// Delay for the next request is taken here
			waited <= 0;
			target <= int'(rdelay);
			reads <= reads + 1;
		end else if (rvalid) begin
			waited <= waited + 1;
		end else begin
			waited <= 0;
		end
	end

endmodule

/* src/sprite_controller.sv */
/*
 * Scanline sprite controller
 *
 * Attribute RAMs written by the host, a per-line renderer that pulls
 * pixels from sprite-sheet memory, and a double-buffered scanline RAM
 * read by the display
 */

module sprite_controller (
	input  logic                                  CLK,
	input  logic                                  RSTb,

	// Host attribute write port
	input  logic [sprite_pkg::HOST_ADDR_BITS-1:0] ADDRESS,
	input  logic [sprite_pkg::WORD_BITS-1:0]      DATA_IN,
	input  logic                                  WR,

	// Single-cycle pulse at the start of each line
	input  logic                                  H_tick,

	// Display readout
	input  logic [sprite_pkg::X_BITS-1:0]         display_x,
	input  logic [sprite_pkg::X_BITS-1:0]         display_y,
	output sprite_pkg::pixel_t                    color_index,

	// Sprite-sheet memory channel
	output logic [sprite_pkg::MEM_ADDR_BITS-1:0]  memory_address,
	input  logic [sprite_pkg::WORD_BITS-1:0]      memory_data,
	output logic                                  rvalid,
	input  logic                                  rready,

	output logic                                  render_busy
);

	import sprite_pkg::*;

	logic [SPRITE_IDX_BITS-1:0] sprite_idx;
	sprite_attr_t               attr;
	pixel_wr_t                  pix_wr;

	sprite_attr_regs u_attr (
		.CLK       (CLK),
		.ADDRESS   (ADDRESS),
		.DATA_IN   (DATA_IN),
		.WR        (WR),
		.sprite_idx(sprite_idx),
		.attr      (attr)
	);

	sprite_renderer u_render (
		.CLK           (CLK),
		.RSTb          (RSTb),
		.H_tick        (H_tick),
		.display_y     (display_y),
		.attr          (attr),
		.sprite_idx    (sprite_idx),
		.memory_address(memory_address),
		.rvalid        (rvalid),
		.rready        (rready),
		.memory_data   (memory_data),
		.pix_wr        (pix_wr),
		.render_busy   (render_busy)
	);

	scanline_buffer u_line (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.H_tick     (H_tick),
		.pix_wr     (pix_wr),
		.display_x  (display_x),
		.color_index(color_index)
	);

endmodule

/* src/scanline_buffer.sv */
/*
 * Double-buffered scanline RAM
 *
 * The renderer fills the active line while the display reads the
 * other one; each displayed location is zeroed one cycle behind the
 * read, and H_tick swaps the two
 */

module scanline_buffer (
	input  logic                          CLK,
	input  logic                          RSTb,
	input  logic                          H_tick,
	input  sprite_pkg::pixel_wr_t         pix_wr,
	input  logic [sprite_pkg::X_BITS-1:0] display_x,
	output sprite_pkg::pixel_t            color_index
);

	import sprite_pkg::*;

	logic              active;
	logic              rd_sel;
	logic [X_BITS-1:0] clear_x;

	logic [X_BITS-1:0] wr_addr [2];
	pixel_t            wr_data [2];
	logic              wr_en [2];
	pixel_t            rd_data [2];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			active <= 1'b0;
			rd_sel <= 1'b1;
		end else begin
			if (H_tick) begin
				active <= ~active;
			end
			// Read data lags by one cycle, so does its buffer select
			rd_sel <= ~active;
		end
	end

	// Previous display location, wrapping to the line end
	assign clear_x = (display_x == '0) ? X_BITS'(SCREEN_W - 1) : display_x - 1'b1;

	for (genvar j = 0; j < 2; j++) begin : g_line
		logic own;

		assign own = (active == 1'(j));
		assign wr_addr[j] = own ? pix_wr.x : clear_x;
		assign wr_data[j] = own ? pix_wr.px : '0;
		assign wr_en[j] = own ? pix_wr.wr : 1'b1;

		bram #(.word_t(pixel_t), .ADDR_BITS(X_BITS)) u_line (
			.CLK    (CLK),
			.rd_addr(display_x),
			.rd_data(rd_data[j]),
			.wr_addr(wr_addr[j]),
			.wr_data(wr_data[j]),
			.wr     (wr_en[j])
		);
	end

	assign color_index = rd_data[rd_sel];

endmodule

/* src/sprite_renderer.sv */
/*
 * Scanline sprite renderer
 *
 * Restarts at sprite 0 on every H_tick, tests each sprite against the
 * current display line, fetches 16-bit sheet words over the memory
 * channel and emits one pixel write per blit cycle, low nibble first
 */

module sprite_renderer (
	input  logic                                   CLK,
	input  logic                                   RSTb,
	input  logic                                   H_tick,
	input  logic [sprite_pkg::X_BITS-1:0]          display_y,
	input  sprite_pkg::sprite_attr_t               attr,
	output logic [sprite_pkg::SPRITE_IDX_BITS-1:0] sprite_idx,
	output logic [sprite_pkg::MEM_ADDR_BITS-1:0]   memory_address,
	output logic                                   rvalid,
	input  logic                                   rready,
	input  logic [sprite_pkg::WORD_BITS-1:0]       memory_data,
	output sprite_pkg::pixel_wr_t                  pix_wr,
	output logic                                   render_busy
);

	import sprite_pkg::*;

	typedef enum logic [3:0] {
		S_IDLE, S_BEGIN, S_LOAD, S_ADDR, S_REQ, S_WAIT,
		S_BLIT0, S_BLIT1, S_BLIT2, S_BLIT3, S_FINISH
	} state_t;

	state_t state;

	// Per-sprite working registers
	logic [X_BITS-1:0]           cur_x;
	logic [X_BITS-1:0]           v_row;
	logic [3:0]                  pal;
	logic [WIDTH_BITS-1:0]       u;
	logic [NIBBLE_ADDR_BITS-1:0] nib_addr;
	logic [WORD_BITS-1:0]        word;

	logic                        accept;
	logic                        last_sprite;
	logic                        last_pixel;
	logic [NIBBLE_ADDR_BITS-1:0] stride;
	logic [NIBBLE_ADDR_BITS-1:0] fetch_addr;
	logic                        in_blit;
	logic [1:0]                  nib_sel;
	logic [NIBBLE_BITS-1:0]      nibble;

	assign accept = attr.x.enable && (display_y >= attr.y.y_start) &&
		(display_y <= attr.y_end);
	assign last_sprite = (sprite_idx == SPRITE_IDX_BITS'(SPRITE_COUNT - 1));
	assign last_pixel = (u == attr.y.width);

	// Sheet base plus row offset plus pixels already drawn
	assign stride = attr.x.stride_wide ? NIBBLE_ADDR_BITS'(STRIDE_WIDE) :
		NIBBLE_ADDR_BITS'(STRIDE_NARROW);
	assign fetch_addr = {attr.sheet_addr, 2'b00} + NIBBLE_ADDR_BITS'(v_row) * stride +
		NIBBLE_ADDR_BITS'(u);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= S_IDLE;
			sprite_idx <= '0;
		end else if (H_tick) begin
			// New line, drop whatever is in flight
			state <= S_BEGIN;
			sprite_idx <= '0;
		end else begin
			case (state)
				S_BEGIN: state <= S_LOAD;
				S_LOAD, S_FINISH: begin
					if (state == S_LOAD && accept) begin
						state <= S_ADDR;
					end else begin
						sprite_idx <= sprite_idx + 1'b1;
						state <= last_sprite ? S_IDLE : S_BEGIN;
					end
				end
				S_ADDR: state <= S_REQ;
				S_REQ: state <= S_WAIT;
				S_WAIT: begin
					if (rready) begin
						state <= S_BLIT0;
					end
				end
				S_BLIT0: state <= last_pixel ? S_FINISH : S_BLIT1;
				S_BLIT1: state <= last_pixel ? S_FINISH : S_BLIT2;
				S_BLIT2: state <= last_pixel ? S_FINISH : S_BLIT3;
				S_BLIT3: state <= last_pixel ? S_FINISH : S_ADDR;
				default: ;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		case (state)
			S_LOAD: begin
				cur_x <= attr.x.x_pos;
				u <= '0;
				pal <= attr.x.pal_high;
				v_row <= display_y - attr.y.y_start;
			end
			S_ADDR: nib_addr <= fetch_addr;
			S_WAIT: begin
				if (rready) begin
					word <= memory_data;
				end
			end
			S_BLIT0, S_BLIT1, S_BLIT2, S_BLIT3: begin
				cur_x <= cur_x + 1'b1;
				u <= u + 1'b1;
			end
			default: ;
		endcase
	end

	// Which nibble of the fetched word this blit cycle draws
	always_comb begin
		in_blit = 1'b1;
		case (state)
			S_BLIT0: nib_sel = 2'd0;
			S_BLIT1: nib_sel = 2'd1;
			S_BLIT2: nib_sel = 2'd2;
			S_BLIT3: nib_sel = 2'd3;
			default: begin
				in_blit = 1'b0;
				nib_sel = 2'd0;
			end
		endcase
	end

	assign nibble = word[NIBBLE_BITS*nib_sel +: NIBBLE_BITS];

	// Zero pixels are transparent
	always_comb begin
		pix_wr.wr = in_blit && (nibble != '0) && !H_tick;
		pix_wr.x = cur_x;
		pix_wr.px.pal_high = pal;
		pix_wr.px.nibble = nibble;
	end

	assign memory_address = nib_addr[NIBBLE_ADDR_BITS-1:2];
	assign rvalid = (state == S_REQ) || (state == S_WAIT);
	assign render_busy = (state != S_IDLE);

	a_rvalid_held: assert property (@(posedge CLK) disable iff (!RSTb)
		(rvalid && !rready && render_busy && !H_tick) |=> rvalid)
		else $error("rvalid dropped before rready");

	a_addr_stable: assert property (@(posedge CLK) disable iff (!RSTb)
		(rvalid && !rready && !H_tick) |=> $stable(memory_address))
		else $error("memory_address changed while waiting for rready");

endmodule

/* src/sprite_attr_regs.sv */
/*
 * Sprite attribute RAMs
 *
 * Host writes land in the X, Y, H or A RAM picked by the top address
 * bits; the renderer reads all four at one sprite index and gets the
 * whole record one cycle later
 */

module sprite_attr_regs (
	input  logic                                   CLK,
	input  logic [sprite_pkg::HOST_ADDR_BITS-1:0]  ADDRESS,
	input  logic [sprite_pkg::WORD_BITS-1:0]       DATA_IN,
	input  logic                                   WR,
	input  logic [sprite_pkg::SPRITE_IDX_BITS-1:0] sprite_idx,
	output sprite_pkg::sprite_attr_t               attr
);

	import sprite_pkg::*;

	logic [ATTR_SEL_BITS-1:0]   sel;
	logic [SPRITE_IDX_BITS-1:0] wr_idx;
	logic [2**ATTR_SEL_BITS-1:0] wr_sel;

	sprite_x_t               x_out;
	sprite_y_t               y_out;
	logic [X_BITS-1:0]       h_out;
	logic [WORD_BITS-1:0]    a_out;

	assign sel = ADDRESS[HOST_ADDR_BITS-1 -: ATTR_SEL_BITS];
	assign wr_idx = ADDRESS[SPRITE_IDX_BITS-1:0];

	// One strobe per RAM
	always_comb begin
		wr_sel = '0;
		wr_sel[sel] = WR;
	end

	bram #(.word_t(sprite_x_t), .ADDR_BITS(SPRITE_IDX_BITS)) u_xram (
		.CLK(CLK), .rd_addr(sprite_idx), .rd_data(x_out),
		.wr_addr(wr_idx), .wr_data(sprite_x_t'(DATA_IN)), .wr(wr_sel[SEL_XRAM])
	);

	bram #(.word_t(sprite_y_t), .ADDR_BITS(SPRITE_IDX_BITS)) u_yram (
		.CLK(CLK), .rd_addr(sprite_idx), .rd_data(y_out),
		.wr_addr(wr_idx), .wr_data(sprite_y_t'(DATA_IN)), .wr(wr_sel[SEL_YRAM])
	);

	// Upper bits of the H word are reserved and not stored
	bram #(.word_t(logic [X_BITS-1:0]), .ADDR_BITS(SPRITE_IDX_BITS)) u_hram (
		.CLK(CLK), .rd_addr(sprite_idx), .rd_data(h_out),
		.wr_addr(wr_idx), .wr_data(DATA_IN[X_BITS-1:0]), .wr(wr_sel[SEL_HRAM])
	);

	bram #(.word_t(logic [WORD_BITS-1:0]), .ADDR_BITS(SPRITE_IDX_BITS)) u_aram (
		.CLK(CLK), .rd_addr(sprite_idx), .rd_data(a_out),
		.wr_addr(wr_idx), .wr_data(DATA_IN), .wr(wr_sel[SEL_ARAM])
	);

	assign attr = '{x: x_out, y: y_out, y_end: h_out, sheet_addr: a_out};

	// An unknown address would scatter the write over the RAMs
	a_write_addr_known: assert property (@(posedge CLK) WR |-> !$isunknown(ADDRESS))
		else $error("host write with an unknown attribute address");

endmodule

/* src/bram.sv */
/*
 * Simple dual-port block RAM
 *
 * One write port and one registered read port on a single clock,
 * word type chosen by the instance
 */

module bram #(
	parameter type word_t = logic [15:0],
	parameter int ADDR_BITS = 8
) (
	input  logic                 CLK,
	input  logic [ADDR_BITS-1:0] rd_addr,
	output word_t                rd_data,
	input  logic [ADDR_BITS-1:0] wr_addr,
	input  word_t                wr_data,
	input  logic                 wr
);

	word_t mem [2**ADDR_BITS];

	always_ff @(posedge CLK) begin
		if (wr) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Old data on a read of the address being written
	always_ff @(posedge CLK) begin
		rd_data <= mem[rd_addr];
	end

endmodule

/* src/sprite_pkg.sv */
/*
 * Sprite engine shared definitions
 *
 * Display geometry, host address map, attribute RAM word layouts
 * and the pixel records passed between renderer and line buffers
 */

package sprite_pkg;

	// Display geometry
	localparam int SCREEN_W = 800;
	localparam int X_BITS = 10;

	// Sprite table
	localparam int SPRITE_COUNT = 256;
	localparam int SPRITE_IDX_BITS = 8;
	localparam int WIDTH_BITS = 6;

	// Host port, top bits of ADDRESS pick the attribute RAM
	localparam int WORD_BITS = 16;
	localparam int ATTR_SEL_BITS = 2;
	localparam int HOST_ADDR_BITS = SPRITE_IDX_BITS + ATTR_SEL_BITS;
	localparam logic [ATTR_SEL_BITS-1:0] SEL_XRAM = 2'd0;
	localparam logic [ATTR_SEL_BITS-1:0] SEL_YRAM = 2'd1;
	localparam logic [ATTR_SEL_BITS-1:0] SEL_HRAM = 2'd2;
	localparam logic [ATTR_SEL_BITS-1:0] SEL_ARAM = 2'd3;

	// Sprite sheet addressing, in 4-bit pixels
	localparam int NIBBLE_BITS = 4;
	localparam int STRIDE_NARROW = 128;
	localparam int STRIDE_WIDE = 256;
	localparam int NIBBLE_ADDR_BITS = 18;
	localparam int MEM_ADDR_BITS = NIBBLE_ADDR_BITS - 2;

	// X RAM word, LSB is x_pos bit 0
	typedef struct packed {
		logic                   stride_wide;
		logic [3:0]             pal_high;
		logic                   enable;
		logic [X_BITS-1:0]      x_pos;
	} sprite_x_t;

	// Y RAM word
	typedef struct packed {
		logic [WIDTH_BITS-1:0]  width;
		logic [X_BITS-1:0]      y_start;
	} sprite_y_t;

	typedef struct packed {
		sprite_x_t              x;
		sprite_y_t              y;
		logic [X_BITS-1:0]      y_end;
		logic [WORD_BITS-1:0]   sheet_addr;
	} sprite_attr_t;

	// Colour index, palette nibble on top
	typedef struct packed {
		logic [3:0]             pal_high;
		logic [NIBBLE_BITS-1:0] nibble;
	} pixel_t;

	typedef struct packed {
		logic                   wr;
		logic [X_BITS-1:0]      x;
		pixel_t                 px;
	} pixel_wr_t;

endpackage
